//--- design/vlsu_pkg.sv
/*
  Shared definitions for the vector load/store unit:
  widths, the two-view instruction union, the exception
  encoding and the size decode helpers
*/

package vlsu_pkg;

  localparam int XLEN  = 64;
  localparam int TAG_W = 6;

  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;

  // I-type view
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } ld_inst_t;

  // S-type view, immediate split around rs2/rs1
  typedef struct packed {
    logic [6:0]  imm_hi;
    logic [4:0]  rs2;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  imm_lo;
    logic [6:0]  opcode;
  } st_inst_t;

  typedef union packed {
    ld_inst_t ld;
    st_inst_t st;
  } inst_u;

  typedef enum logic [2:0] {
    NONE,
    ILLEGAL_INST,
    LD_MISALIGN,
    LD_ACC_FAULT,
    ST_MISALIGN,
    ST_ACC_FAULT
  } except_e;

  // 0 flags an unsupported size
  function automatic logic [3:0] size_bytes(input logic [2:0] funct3);
    case (funct3)
      3'd0:    return 4'd1;
      3'd1:    return 4'd2;
      3'd2:    return 4'd4;
      3'd3:    return 4'd8;
      default: return 4'd0;
    endcase
  endfunction

  // Byte lanes touched at offset 0
  function automatic logic [XLEN/8-1:0] size_be(input logic [2:0] funct3);
    case (funct3)
      3'd0:    return 8'h01;
      3'd1:    return 8'h03;
      3'd2:    return 8'h0f;
      default: return 8'hff;
    endcase
  endfunction

  // Bit mask for zero extension of load data
  function automatic logic [XLEN-1:0] size_data_mask(input logic [2:0] funct3);
    logic [XLEN/8-1:0] be;
    logic [XLEN-1:0]   mask;
    be = size_be(funct3);
    for (int b = 0; b < XLEN/8; b++) begin
      mask[b*8 +: 8] = {8{be[b]}};
    end
    return mask;
  endfunction

endpackage

//--- design/vlsu_if.sv
/*
  Interfaces between dispatch, pipes, data RAM and merger:
  issue strobe with payload, done report, RAM access port
*/

`timescale 1ns/1ps

interface vlsu_issue_if;
  import vlsu_pkg::*;

  logic             valid;   // One-cycle strobe
  inst_u            inst;
  logic [XLEN-1:0]  base;
  logic [XLEN-1:0]  st_data;
  logic [TAG_W-1:0] tag;

  modport dispatch (output valid, inst, base, st_data, tag);
  modport pipe     (input  valid, inst, base, st_data, tag);
endinterface

interface vlsu_done_if;
  import vlsu_pkg::*;

  logic             valid;
  logic [TAG_W-1:0] tag;
  logic             except_valid;
  except_e          except_type;
  logic [XLEN-1:0]  tval;
  logic [XLEN-1:0]  data;   // Aligned, zero-extended load data

  modport pipe  (output valid, tag, except_valid, except_type, tval, data);
  modport merge (input  valid, tag, except_valid, except_type, tval, data);
endinterface

interface vlsu_mem_if;
  import vlsu_pkg::*;

  logic               rd_en;
  logic [XLEN-1:0]    addr;     // Word-aligned byte address
  logic               wr_en;
  logic [XLEN/8-1:0]  wr_be;
  logic [XLEN-1:0]    wr_data;
  logic [XLEN-1:0]    rd_data;  // One cycle after rd_en

  modport pipe (output rd_en, addr, wr_en, wr_be, wr_data, input rd_data);
  modport ram  (input rd_en, addr, wr_en, wr_be, wr_data, output rd_data);
endinterface

//--- design/vlsu_dispatch.sv
/*
  Round-robin dispatcher
  Registers each accepted operation into one pipe's issue port
*/

`timescale 1ns/1ps

module vlsu_dispatch #(
  parameter int NUM_PIPES = 3
) (
  input  logic                      i_clk,
  input  logic                      i_reset_n,
  input  logic                      i_flush,
  input  logic                      i_issue_valid,
  input  logic [31:0]               i_issue_inst,
  input  logic [vlsu_pkg::XLEN-1:0] i_issue_base,
  input  logic [vlsu_pkg::XLEN-1:0] i_issue_st_data,
  input  logic [vlsu_pkg::TAG_W-1:0] i_issue_tag,
  vlsu_issue_if.dispatch            o_issue [NUM_PIPES]
);

  localparam int PTR_W = (NUM_PIPES > 1) ? $clog2(NUM_PIPES) : 1;

  logic [PTR_W-1:0] r_ptr;
  logic             w_accept;

  // Flush in the sampling cycle drops the op
  assign w_accept = i_issue_valid & ~i_flush;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ptr <= '0;
    end else if (w_accept) begin
      r_ptr <= (r_ptr == PTR_W'(NUM_PIPES - 1)) ? '0 : r_ptr + 1'b1;
    end
  end

  // --------------------------------------------------
  // Per-pipe issue registers
  // --------------------------------------------------
  for (genvar p = 0; p < NUM_PIPES; p++) begin : g_issue
    logic w_sel;

    assign w_sel = w_accept && (r_ptr == PTR_W'(p));

    always_ff @(posedge i_clk, negedge i_reset_n) begin
      if (!i_reset_n) begin
        o_issue[p].valid <= 1'b0;
      end else begin
        o_issue[p].valid <= w_sel;   // Other pipes see a cleared strobe
      end
    end

    always_ff @(posedge i_clk) begin
      if (w_sel) begin
        o_issue[p].inst    <= i_issue_inst;
        o_issue[p].base    <= i_issue_base;
        o_issue[p].st_data <= i_issue_st_data;
        o_issue[p].tag     <= i_issue_tag;
      end
    end
  end

endmodule

//--- design/vlsu_pipe.sv
/*
  One load/store pipe
  EX1 decode, address, check and RAM request
  EX2 RAM read return, EX3 aligned data and done report
*/

`timescale 1ns/1ps

module vlsu_pipe #(
  parameter int RAM_WORDS = 64
) (
  input  logic        i_clk,
  input  logic        i_reset_n,
  input  logic        i_flush,
  vlsu_issue_if.pipe  i_issue,
  vlsu_mem_if.pipe    o_mem,
  vlsu_done_if.pipe   o_done
);
  import vlsu_pkg::*;

  inst_u             w_ex1_inst;
  logic              w_ex1_is_load;
  logic              w_ex1_is_store;
  logic [2:0]        w_ex1_funct3;
  logic [3:0]        w_ex1_nbytes;
  logic [2:0]        w_ex1_off_mask;
  logic [11:0]       w_ex1_imm;
  logic [XLEN-1:0]   w_ex1_addr;
  logic              w_ex1_misalign;
  logic              w_ex1_out_of_range;
  except_e           w_ex1_except_type;
  logic              w_ex1_except_valid;

  logic              r_ex2_valid;
  logic [TAG_W-1:0]  r_ex2_tag;
  logic              r_ex2_is_load;
  logic [2:0]        r_ex2_funct3;
  logic              r_ex2_except_valid;
  except_e           r_ex2_except_type;
  logic [XLEN-1:0]   r_ex2_addr;
  logic [XLEN-1:0]   w_ex2_data;

  logic              r_ex3_valid;
  logic [TAG_W-1:0]  r_ex3_tag;
  logic              r_ex3_except_valid;
  except_e           r_ex3_except_type;
  logic [XLEN-1:0]   r_ex3_addr;
  logic [XLEN-1:0]   r_ex3_data;

  // --------------------------------------------------
  // EX1
  // --------------------------------------------------
  assign w_ex1_inst     = i_issue.inst;
  assign w_ex1_is_load  = (w_ex1_inst.ld.opcode == OPC_LOAD);   // Opcode shared by both views
  assign w_ex1_is_store = (w_ex1_inst.st.opcode == OPC_STORE);

  assign w_ex1_funct3 = w_ex1_inst.ld.funct3;   // Same field in both views
  assign w_ex1_imm    = w_ex1_is_store ? {w_ex1_inst.st.imm_hi, w_ex1_inst.st.imm_lo}
                                       : w_ex1_inst.ld.imm12;
  assign w_ex1_nbytes = size_bytes(w_ex1_funct3);

  assign w_ex1_addr = i_issue.base + {{(XLEN-12){w_ex1_imm[11]}}, w_ex1_imm};

  assign w_ex1_off_mask     = w_ex1_nbytes[2:0] - 3'd1;   // 8 bytes wraps to 3'b111
  assign w_ex1_misalign     = (w_ex1_addr[2:0] & w_ex1_off_mask) != 3'd0;
  assign w_ex1_out_of_range = w_ex1_addr[XLEN-1:3] >= (XLEN-3)'(RAM_WORDS);

  // Illegal, then misalign, then access fault
  always_comb begin
    w_ex1_except_type = NONE;
    if (!(w_ex1_is_load || w_ex1_is_store) || (w_ex1_nbytes == 4'd0)) begin
      w_ex1_except_type = ILLEGAL_INST;
    end else if (w_ex1_misalign) begin
      w_ex1_except_type = w_ex1_is_load ? LD_MISALIGN : ST_MISALIGN;
    end else if (w_ex1_out_of_range) begin
      w_ex1_except_type = w_ex1_is_load ? LD_ACC_FAULT : ST_ACC_FAULT;
    end
  end

  assign w_ex1_except_valid = (w_ex1_except_type != NONE);

  // Store write is dropped by a flush in this cycle
  assign o_mem.rd_en   = i_issue.valid & w_ex1_is_load & ~w_ex1_except_valid;
  assign o_mem.wr_en   = i_issue.valid & w_ex1_is_store & ~w_ex1_except_valid & ~i_flush;
  assign o_mem.addr    = {w_ex1_addr[XLEN-1:3], 3'b000};
  assign o_mem.wr_be   = size_be(w_ex1_funct3) << w_ex1_addr[2:0];
  assign o_mem.wr_data = i_issue.st_data << {w_ex1_addr[2:0], 3'b000};

  // --------------------------------------------------
  // EX2
  // --------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex2_valid <= 1'b0;
      r_ex3_valid <= 1'b0;
    end else begin
      r_ex2_valid <= i_issue.valid & ~i_flush;
      r_ex3_valid <= r_ex2_valid & ~i_flush;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex2_tag          <= i_issue.tag;
    r_ex2_is_load      <= w_ex1_is_load;
    r_ex2_funct3       <= w_ex1_funct3;
    r_ex2_except_valid <= w_ex1_except_valid;
    r_ex2_except_type  <= w_ex1_except_type;
    r_ex2_addr         <= w_ex1_addr;
  end

  // Shift the returned word down to the byte offset
  assign w_ex2_data = (r_ex2_is_load && !r_ex2_except_valid) ?
                      ((o_mem.rd_data >> {r_ex2_addr[2:0], 3'b000}) &
                       size_data_mask(r_ex2_funct3)) : '0;

  // --------------------------------------------------
  // EX3
  // --------------------------------------------------
  always_ff @(posedge i_clk) begin
    r_ex3_tag          <= r_ex2_tag;
    r_ex3_except_valid <= r_ex2_except_valid;
    r_ex3_except_type  <= r_ex2_except_type;
    r_ex3_addr         <= r_ex2_addr;
    r_ex3_data         <= w_ex2_data;
  end

  assign o_done.valid        = r_ex3_valid & ~i_flush;
  assign o_done.tag          = r_ex3_tag;
  assign o_done.except_valid = r_ex3_except_valid;
  assign o_done.except_type  = r_ex3_except_type;
  assign o_done.tval         = r_ex3_except_valid ? r_ex3_addr : '0;
  assign o_done.data         = r_ex3_data;   // Already 0 for stores and faults

endmodule

//--- design/vlsu_data_ram.sv
/*
  Shared data RAM, one port pair per pipe
  Byte-enabled writes, registered reads
*/

`timescale 1ns/1ps

module vlsu_data_ram #(
  parameter int NUM_PIPES = 3,
  parameter int RAM_WORDS = 64
) (
  input  logic     i_clk,
  vlsu_mem_if.ram  i_mem [NUM_PIPES]
);
  import vlsu_pkg::*;

  localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

  logic [XLEN-1:0]    mem [RAM_WORDS] = '{default: '0};
  logic [IDX_W-1:0]   w_idx     [NUM_PIPES];
  logic               w_wr_en   [NUM_PIPES];
  logic [XLEN/8-1:0]  w_wr_be   [NUM_PIPES];
  logic [XLEN-1:0]    w_wr_data [NUM_PIPES];

  for (genvar p = 0; p < NUM_PIPES; p++) begin : g_port
    assign w_idx[p]     = i_mem[p].addr[IDX_W+2:3];   // Word index
    assign w_wr_en[p]   = i_mem[p].wr_en;
    assign w_wr_be[p]   = i_mem[p].wr_be;
    assign w_wr_data[p] = i_mem[p].wr_data;

    // Old data on a same-cycle write to the word
    always_ff @(posedge i_clk) begin
      if (i_mem[p].rd_en) begin
        i_mem[p].rd_data <= mem[w_idx[p]];
      end
    end
  end

  // --------------------------------------------------
  // Write ports
  // --------------------------------------------------
  always_ff @(posedge i_clk) begin
    for (int p = 0; p < NUM_PIPES; p++) begin
      if (w_wr_en[p]) begin
        for (int b = 0; b < XLEN/8; b++) begin
          if (w_wr_be[p][b]) begin
            mem[w_idx[p]][b*8 +: 8] <= w_wr_data[p][b*8 +: 8];
          end
        end
      end
    end
  end

endmodule

//--- design/vlsu_done_merge.sv
/*
  Done merger
  Registers the one report completing per cycle,
  counts excepting operations
*/

`timescale 1ns/1ps

module vlsu_done_merge #(
  parameter int NUM_PIPES = 3
) (
  input  logic                       i_clk,
  input  logic                       i_reset_n,
  vlsu_done_if.merge                 i_done [NUM_PIPES],
  output logic                       o_done_valid,
  output logic [vlsu_pkg::TAG_W-1:0] o_done_tag,
  output logic                       o_done_except_valid,
  output vlsu_pkg::except_e          o_done_except_type,
  output logic [vlsu_pkg::XLEN-1:0]  o_done_tval,
  output logic [vlsu_pkg::XLEN-1:0]  o_done_data,
  output logic [15:0]                o_except_count
);
  import vlsu_pkg::*;

  logic [NUM_PIPES-1:0] w_valid;
  logic [TAG_W-1:0]     w_tag    [NUM_PIPES];
  logic [NUM_PIPES-1:0] w_exc;
  except_e              w_type   [NUM_PIPES];
  logic [XLEN-1:0]      w_tval   [NUM_PIPES];
  logic [XLEN-1:0]      w_data   [NUM_PIPES];

  logic                 w_sel_valid;
  logic [TAG_W-1:0]     w_sel_tag;
  logic                 w_sel_exc;
  except_e              w_sel_type;
  logic [XLEN-1:0]      w_sel_tval;
  logic [XLEN-1:0]      w_sel_data;

  for (genvar p = 0; p < NUM_PIPES; p++) begin : g_in
    assign w_valid[p] = i_done[p].valid;
    assign w_tag[p]   = i_done[p].tag;
    assign w_exc[p]   = i_done[p].except_valid;
    assign w_type[p]  = i_done[p].except_type;
    assign w_tval[p]  = i_done[p].tval;
    assign w_data[p]  = i_done[p].data;
  end

  // Fixed latency keeps this to one valid pipe
  always_comb begin
    w_sel_valid = |w_valid;
    w_sel_tag   = '0;
    w_sel_exc   = 1'b0;
    w_sel_type  = NONE;
    w_sel_tval  = '0;
    w_sel_data  = '0;
    for (int p = 0; p < NUM_PIPES; p++) begin
      if (w_valid[p]) begin
        w_sel_tag  = w_tag[p];
        w_sel_exc  = w_exc[p];
        w_sel_type = w_type[p];
        w_sel_tval = w_tval[p];
        w_sel_data = w_data[p];
      end
    end
  end

  // --------------------------------------------------
  // Output register and exception counter
  // --------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_done_valid   <= 1'b0;
      o_except_count <= '0;
    end else begin
      o_done_valid <= w_sel_valid;
      if (w_sel_valid && w_sel_exc && (o_except_count != 16'hffff)) begin
        o_except_count <= o_except_count + 16'd1;   // Saturates
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_sel_valid) begin
      o_done_tag          <= w_sel_tag;
      o_done_except_valid <= w_sel_exc;
      o_done_except_type  <= w_sel_type;
      o_done_tval         <= w_sel_tval;
      o_done_data         <= w_sel_data;
    end
  end

endmodule

//--- design/vlsu_top.sv
/*
  Load/store unit top level
  Dispatcher, generated pipes, shared data RAM, done merger
*/

`timescale 1ns/1ps

module vlsu_top #(
  parameter int NUM_PIPES = 3,
  parameter int RAM_WORDS = 64
) (
  input  logic                       i_clk,
  input  logic                       i_reset_n,
  input  logic                       i_flush,
  input  logic                       i_issue_valid,
  input  logic [31:0]                i_issue_inst,
  input  logic [vlsu_pkg::XLEN-1:0]  i_issue_base,
  input  logic [vlsu_pkg::XLEN-1:0]  i_issue_st_data,
  input  logic [vlsu_pkg::TAG_W-1:0] i_issue_tag,
  output logic                       o_done_valid,
  output logic [vlsu_pkg::TAG_W-1:0] o_done_tag,
  output logic                       o_done_except_valid,
  output vlsu_pkg::except_e          o_done_except_type,
  output logic [vlsu_pkg::XLEN-1:0]  o_done_tval,
  output logic [vlsu_pkg::XLEN-1:0]  o_done_data,
  output logic [15:0]                o_except_count
);

  vlsu_issue_if issue_if [NUM_PIPES] ();
  vlsu_done_if  done_if  [NUM_PIPES] ();
  vlsu_mem_if   mem_if   [NUM_PIPES] ();

  vlsu_dispatch #(
    .NUM_PIPES (NUM_PIPES)
  ) u_dispatch (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_flush         (i_flush),
    .i_issue_valid   (i_issue_valid),
    .i_issue_inst    (i_issue_inst),
    .i_issue_base    (i_issue_base),
    .i_issue_st_data (i_issue_st_data),
    .i_issue_tag     (i_issue_tag),
    .o_issue         (issue_if)
  );

  // --------------------------------------------------
  // Load/store pipes
  // --------------------------------------------------
  for (genvar g = 0; g < NUM_PIPES; g++) begin : g_pipe
    vlsu_pipe #(
      .RAM_WORDS (RAM_WORDS)
    ) u_pipe (
      .i_clk     (i_clk),
      .i_reset_n (i_reset_n),
      .i_flush   (i_flush),
      .i_issue   (issue_if[g]),
      .o_mem     (mem_if[g]),
      .o_done    (done_if[g])
    );
  end

  vlsu_data_ram #(
    .NUM_PIPES (NUM_PIPES),
    .RAM_WORDS (RAM_WORDS)
  ) u_data_ram (
    .i_clk (i_clk),
    .i_mem (mem_if)
  );

  vlsu_done_merge #(
    .NUM_PIPES (NUM_PIPES)
  ) u_done_merge (
    .i_clk               (i_clk),
    .i_reset_n           (i_reset_n),
    .i_done              (done_if),
    .o_done_valid        (o_done_valid),
    .o_done_tag          (o_done_tag),
    .o_done_except_valid (o_done_except_valid),
    .o_done_except_type  (o_done_except_type),
    .o_done_tval         (o_done_tval),
    .o_done_data         (o_done_data),
    .o_except_count      (o_except_count)
  );

endmodule

//--- test/vlsu_chk.sv
/*
  Bound assertions on the load/store unit top level:
  single RAM writer per cycle, one done strobe per tag,
  no done report right after reset
*/

`timescale 1ns/1ps

module vlsu_chk #(
  parameter int NUM_PIPES = 3
) (
  input logic                       i_clk,
  input logic                       i_reset_n,
  input logic                       i_done_valid,
  input logic [vlsu_pkg::TAG_W-1:0] i_done_tag,
  input logic                       i_wr_en [NUM_PIPES]
);

  int w_wr_cnt;

  always_comb begin
    w_wr_cnt = 0;
    for (int p = 0; p < NUM_PIPES; p++) begin
      if (i_wr_en[p]) begin
        w_wr_cnt++;
      end
    end
  end

  a_one_writer: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    w_wr_cnt <= 1)
    else $error("More than one pipe wrote the data RAM in one cycle");

  // Same tag must not report on two consecutive cycles
  a_done_strobe: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_done_valid |=> !(i_done_valid && (i_done_tag == $past(i_done_tag))))
    else $error("Done strobe held for two cycles on one tag");

  a_quiet_after_reset: assert property (@(posedge i_clk)
    $rose(i_reset_n) |-> !i_done_valid [*4])
    else $error("Done report within 4 edges after reset");

endmodule

bind vlsu_top vlsu_chk #(
  .NUM_PIPES (NUM_PIPES)
) chk_i (
  .i_clk        (i_clk),
  .i_reset_n    (i_reset_n),
  .i_done_valid (o_done_valid),
  .i_done_tag   (o_done_tag),
  .i_wr_en      (u_data_ram.w_wr_en)
);

//--- test/tb_vlsu_top.sv
/*
  Testbench for the load/store unit top level
  Stimulus table built through a reference memory model,
  applied in a loop, with typed compare tasks and a summary
*/

`timescale 1ns/1ps

module tb_vlsu_top;
  import vlsu_pkg::*;

  localparam int NUM_PIPES     = 3;
  localparam int RAM_WORDS     = 64;
  localparam int LATENCY       = 4;    // Rising edges from issue to report
  localparam int DRAIN_TIMEOUT = 50;

  typedef struct {
    string            desc;
    logic [31:0]      inst;
    logic [XLEN-1:0]  base;
    logic [XLEN-1:0]  st_data;
    bit               flush;
    int               idle;       // Idle cycles after this row
    except_e          exp_type;
    logic [XLEN-1:0]  exp_tval;
    logic [XLEN-1:0]  exp_data;
    int               cyc;        // Planned issue slot
    int               issued;     // Edge count at drive time
    bit               killed;
    bit               wrote;
    int               widx;
    logic [XLEN-1:0]  old_word;
  } row_t;

  logic             i_clk;
  logic             i_reset_n;
  logic             i_flush;
  logic             i_issue_valid;
  logic [31:0]      i_issue_inst;
  logic [XLEN-1:0]  i_issue_base;
  logic [XLEN-1:0]  i_issue_st_data;
  logic [TAG_W-1:0] i_issue_tag;
  logic             o_done_valid;
  logic [TAG_W-1:0] o_done_tag;
  logic             o_done_except_valid;
  except_e          o_done_except_type;
  logic [XLEN-1:0]  o_done_tval;
  logic [XLEN-1:0]  o_done_data;
  logic [15:0]      o_except_count;

  row_t            rows [$];
  int              exp_q [$];
  logic [XLEN-1:0] ref_mem [RAM_WORDS];
  integer          seed;
  int              cyc_cnt = 0;
  int              next_cyc = 0;
  int              err_cnt = 0;
  int              test_cnt = 0;
  int              flush_cnt = 0;

  vlsu_top #(
    .NUM_PIPES (NUM_PIPES),
    .RAM_WORDS (RAM_WORDS)
  ) dut_i (
    .i_clk               (i_clk),
    .i_reset_n           (i_reset_n),
    .i_flush             (i_flush),
    .i_issue_valid       (i_issue_valid),
    .i_issue_inst        (i_issue_inst),
    .i_issue_base        (i_issue_base),
    .i_issue_st_data     (i_issue_st_data),
    .i_issue_tag         (i_issue_tag),
    .o_done_valid        (o_done_valid),
    .o_done_tag          (o_done_tag),
    .o_done_except_valid (o_done_except_valid),
    .o_done_except_type  (o_done_except_type),
    .o_done_tval         (o_done_tval),
    .o_done_data         (o_done_data),
    .o_except_count      (o_except_count)
  );

  initial begin
    i_clk = 1'b0;
    forever begin
      #20 i_clk = ~i_clk;
    end
  end

  always @(posedge i_clk) cyc_cnt <= cyc_cnt + 1;

  // --------------------------------------------------
  // Instruction encoding and reference model
  // --------------------------------------------------
  function automatic logic [31:0] enc_load(input logic [2:0] f3, input logic [11:0] imm);
    return {imm, 5'd1, f3, 5'd2, OPC_LOAD};
  endfunction

  function automatic logic [31:0] enc_store(input logic [2:0] f3, input logic [11:0] imm);
    return {imm[11:5], 5'd3, 5'd1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [XLEN-1:0] rand_word();
    return {$random(seed), $random(seed)};
  endfunction

  // Flush at slot c kills slots c-3..c, only the EX1 store loses its write
  task automatic kill_in_flight(input int c);
    for (int j = rows.size() - 1; j >= 0; j--) begin
      if (rows[j].cyc < c - 3) break;
      rows[j].killed = 1'b1;
      if (rows[j].cyc >= c - 1 && rows[j].wrote) begin
        ref_mem[rows[j].widx] = rows[j].old_word;
        rows[j].wrote = 1'b0;
      end
    end
  endtask

  task automatic add_row(input string desc, input logic [31:0] inst,
                         input logic [XLEN-1:0] base, input logic [XLEN-1:0] st_data,
                         input bit flush, input int idle);
    row_t            r;
    bit              is_ld;
    bit              is_st;
    logic [2:0]      f3;
    logic [11:0]     imm;
    logic [XLEN-1:0] addr;
    int              nb;
    int              off;
    is_ld = (inst[6:0] == OPC_LOAD);
    is_st = (inst[6:0] == OPC_STORE);
    f3    = inst[14:12];
    imm   = is_st ? {inst[31:25], inst[11:7]} : inst[31:20];
    addr  = base + {{(XLEN-12){imm[11]}}, imm};
    nb    = 1 << f3;
    off   = addr[2:0];
    r = '{desc: desc, inst: inst, base: base, st_data: st_data, flush: flush, idle: idle,
          exp_type: NONE, exp_tval: '0, exp_data: '0, cyc: next_cyc, issued: 0,
          killed: flush, wrote: 1'b0, widx: 0, old_word: '0};
    next_cyc += 1 + idle;
    if (!(is_ld || is_st) || f3 > 3'd3) begin
      r.exp_type = ILLEGAL_INST;
    end else if ((addr & (nb - 1)) != 0) begin
      r.exp_type = is_ld ? LD_MISALIGN : ST_MISALIGN;
    end else if (addr[XLEN-1:3] >= RAM_WORDS) begin
      r.exp_type = is_ld ? LD_ACC_FAULT : ST_ACC_FAULT;
    end
    if (r.exp_type != NONE) r.exp_tval = addr;
    if (flush) begin
      kill_in_flight(r.cyc);
    end else if (r.exp_type == NONE) begin
      r.widx = int'(addr[12:3]);
      if (is_ld) begin
        for (int k = 0; k < nb; k++) r.exp_data[8*k +: 8] = ref_mem[r.widx][8*(off+k) +: 8];
      end else begin
        r.old_word = ref_mem[r.widx];
        r.wrote    = 1'b1;
        for (int k = 0; k < nb; k++) ref_mem[r.widx][8*(off+k) +: 8] = st_data[8*k +: 8];
      end
    end
    rows.push_back(r);
  endtask

  task automatic build_table();
    // Store then load of every size, back to back
    add_row("sb", enc_store(3'd0, 12'h001), 64'h10, rand_word(), 0, 0);
    add_row("sh", enc_store(3'd1, 12'h002), 64'h20, rand_word(), 0, 0);
    add_row("sw", enc_store(3'd2, 12'h004), 64'h30, rand_word(), 0, 0);
    add_row("sd negative imm", enc_store(3'd3, 12'hfe8), 64'h60, rand_word(), 0, 0);
    add_row("sd", enc_store(3'd3, 12'h000), 64'h88, rand_word(), 0, 0);
    add_row("sd last word", enc_store(3'd3, 12'h000), 64'h1f8, rand_word(), 0, 0);
    add_row("lb", enc_load(3'd0, 12'h001), 64'h10, '0, 0, 0);
    add_row("lh", enc_load(3'd1, 12'h002), 64'h20, '0, 0, 0);
    add_row("lw", enc_load(3'd2, 12'h004), 64'h30, '0, 0, 0);
    add_row("ld negative imm", enc_load(3'd3, 12'hff8), 64'h50, '0, 0, 0);
    add_row("ld word of sb", enc_load(3'd3, 12'h000), 64'h10, '0, 0, 0);
    add_row("ld last word", enc_load(3'd3, 12'h000), 64'h1f8, '0, 0, 2);
    // Misalignment
    add_row("lh misaligned", enc_load(3'd1, 12'h003), 64'h20, '0, 0, 0);
    add_row("lw misaligned", enc_load(3'd2, 12'h006), 64'h30, '0, 0, 0);
    add_row("sd misaligned", enc_store(3'd3, 12'h004), 64'h48, rand_word(), 0, 0);
    add_row("sw misaligned", enc_store(3'd2, 12'h002), 64'h48, rand_word(), 0, 0);
    add_row("ld after bad stores", enc_load(3'd3, 12'h000), 64'h48, '0, 0, 1);
    // Range faults and a bad opcode
    add_row("ld out of range", enc_load(3'd3, 12'h000), 64'h200, '0, 0, 0);
    add_row("sb wrapped addr", enc_store(3'd0, 12'hfff), 64'h0, rand_word(), 0, 0);
    add_row("lw far addr", enc_load(3'd2, 12'h010), 64'h1000_0000_0000, '0, 0, 0);
    add_row("lh misalign and range", enc_load(3'd1, 12'h001), 64'h200, '0, 0, 0);
    add_row("bad opcode", 32'h0041_00b3, 64'h80, '0, 0, 4);
    // Flush over a full pipeline
    add_row("ld before flush", enc_load(3'd3, 12'h000), 64'h48, '0, 0, 0);
    add_row("sd past EX1", enc_store(3'd3, 12'h000), 64'h80, rand_word(), 0, 0);
    add_row("ld in flight", enc_load(3'd3, 12'h000), 64'h80, '0, 0, 0);
    add_row("sd in EX1", enc_store(3'd3, 12'h000), 64'h88, rand_word(), 0, 0);
    add_row("sw with flush", enc_store(3'd2, 12'h000), 64'h90, rand_word(), 1, 0);
    add_row("ld 0x80 after flush", enc_load(3'd3, 12'h000), 64'h80, '0, 0, 0);
    add_row("ld 0x88 after flush", enc_load(3'd3, 12'h000), 64'h88, '0, 0, 0);
    add_row("ld 0x90 after flush", enc_load(3'd3, 12'h000), 64'h90, '0, 0, 0);
  endtask

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------
  task automatic check_tag(input int t, input logic [TAG_W-1:0] got, input logic [TAG_W-1:0] exp);
    if (got !== exp) begin
      $display("Error: o_done_tag in test %0d: got 0x%0h, expected 0x%0h", t, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_except(input int t, input logic got_valid, input except_e got,
                              input except_e exp);
    if (got_valid !== (exp != NONE)) begin
      $display("Error: o_done_except_valid in test %0d: got 0x%0h, expected 0x%0h",
               t, got_valid, exp != NONE);
      err_cnt++;
    end
    if (got !== exp) begin
      $display("Error: o_done_except_type in test %0d: got 0x%0h, expected 0x%0h (%s)",
               t, got, exp, exp.name());
      err_cnt++;
    end
  endtask

  task automatic check_data(input int t, input string name, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("Error: %s in test %0d: got 0x%0h, expected 0x%0h", name, t, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_count(input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
      $display("Error: o_except_count: got 0x%0h, expected 0x%0h", got, exp);
      err_cnt++;
    end
  endtask

  task automatic report_test(input int t, input bit ok);
    test_cnt++;
    $display("test %0d (%s): %s", t, rows[t].desc, ok ? "ok" : "FAIL");
  endtask

  // Sampled on the falling edge, one cycle of the done stream
  task automatic check_outputs();
    int idx;
    int errs;
    if (o_done_valid) begin
      if (exp_q.size() == 0) begin
        $display("Unexpected done report with tag %0d", o_done_tag);
        err_cnt++;
      end else begin
        idx  = exp_q.pop_front();
        errs = err_cnt;
        if (cyc_cnt - rows[idx].issued != LATENCY) begin
          $display("Report for test %0d came %0d edges after issue instead of %0d",
                   idx, cyc_cnt - rows[idx].issued, LATENCY);
          err_cnt++;
        end
        check_tag(idx, o_done_tag, TAG_W'(idx));
        check_except(idx, o_done_except_valid, o_done_except_type, rows[idx].exp_type);
        check_data(idx, "o_done_tval", o_done_tval, rows[idx].exp_tval);
        check_data(idx, "o_done_data", o_done_data, rows[idx].exp_data);
        report_test(idx, err_cnt == errs);
      end
    end else if (exp_q.size() != 0) begin
      if (cyc_cnt - rows[exp_q[0]].issued >= LATENCY) begin
        idx = exp_q.pop_front();
        $display("No done report for test %0d after %0d edges", idx, LATENCY);
        err_cnt++;
        report_test(idx, 1'b0);
      end
    end
  endtask

  task automatic drive_row(input int i);
    i_issue_valid   = 1'b1;
    i_issue_inst    = rows[i].inst;
    i_issue_base    = rows[i].base;
    i_issue_st_data = rows[i].st_data;
    i_issue_tag     = TAG_W'(i);
    i_flush         = rows[i].flush;
    rows[i].issued  = cyc_cnt;
    if (rows[i].killed) begin
      flush_cnt++;
      test_cnt++;
      $display("test %0d (%s): flushed, no report expected", i, rows[i].desc);
    end else begin
      exp_q.push_back(i);
    end
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    int wait_cnt;
    int exp_exc;
    seed            = 32'hfac497c7;
    i_reset_n       = 1'b0;
    i_flush         = 1'b0;
    i_issue_valid   = 1'b0;
    i_issue_inst    = '0;
    i_issue_base    = '0;
    i_issue_st_data = '0;
    i_issue_tag     = '0;
    for (int k = 0; k < RAM_WORDS; k++) ref_mem[k] = '0;
    build_table();

    repeat (4) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;

    for (int i = 0; i < rows.size(); i++) begin
      @(negedge i_clk);
      check_outputs();
      drive_row(i);
      for (int k = 0; k < rows[i].idle; k++) begin
        @(negedge i_clk);
        check_outputs();
        i_issue_valid = 1'b0;
        i_flush       = 1'b0;
      end
    end
    @(negedge i_clk);
    check_outputs();
    i_issue_valid = 1'b0;
    i_flush       = 1'b0;

    wait_cnt = 0;
    while (exp_q.size() != 0 && wait_cnt < DRAIN_TIMEOUT) begin
      @(negedge i_clk);
      check_outputs();
      wait_cnt++;
    end
    if (exp_q.size() != 0) begin
      $display("Timed out with %0d reports still outstanding", exp_q.size());
      err_cnt++;
    end
    repeat (LATENCY) begin   // Window for stray reports
      @(negedge i_clk);
      check_outputs();
    end

    exp_exc = 0;
    foreach (rows[i]) begin
      if (!rows[i].killed && rows[i].exp_type != NONE) exp_exc++;
    end
    check_count(o_except_count, 16'(exp_exc));

    $display("Summary: %0d tests, %0d flushed, %0d errors", test_cnt, flush_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- sim.f
design/vlsu_pkg.sv
design/vlsu_if.sv
design/vlsu_dispatch.sv
design/vlsu_pipe.sv
design/vlsu_data_ram.sv
design/vlsu_done_merge.sv
design/vlsu_top.sv
test/vlsu_chk.sv
test/tb_vlsu_top.sv
